/* compile.f */
logic/cache_pkg.sv
logic/cache_array.sv
logic/cache_controller.sv
logic/backing_memory.sv
logic/cache_subsystem.sv
sim/tb_clock.sv
sim/cache_checker.sv
sim/cache_tb.sv

/* Makefile */
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

FAIL_MSG  := STATUS: FAIL
BIN       := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard logic/*.sv sim/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb
    import cache_pkg::*;
();

    localparam int index_bits     = 6;
    localparam int mem_words_bits = 10;
    localparam int mem_latency    = 3;

    // ********************
    // Run length
    // ********************
    localparam int n_random       = 400;
    localparam int n_requests     = 16 + 2 * 8 + 3 * 4 + n_random + 2 * 4;
    localparam int worst_cycles   = 2 * mem_latency + 10;  // Dirty read miss plus gaps
    localparam int timeout_cycles = n_requests * worst_cycles + 200;

    logic                 clk;
    logic                 rst_b;
    logic                 req;
    logic                 we;
    logic [word_bits-1:0] addr;
    logic [word_bits-1:0] wdata;
    logic                 busy;
    logic                 done;
    logic                 miss;
    logic [word_bits-1:0] rdata;

    // Flat memory and tag table
    logic [31:0] model_mem [128];  // Indexed by {tag, index}
    logic [2:0]  model_tag [16];
    logic [15:0] model_valid;

    logic [31:0] lfsr_state = 32'he905f3ab;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_count = 0;
    int          checks_at_start;
    int          errors_at_start;

    tb_clock #(.period_ns(40)) u_clock (.clk(clk));

    cache_subsystem #(
        .index_bits     (index_bits),
        .mem_words_bits (mem_words_bits),
        .mem_latency    (mem_latency)
    ) dut (
        .clk   (clk),
        .rst_b (rst_b),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .busy  (busy),
        .done  (done),
        .miss  (miss),
        .rdata (rdata)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            $display("timeout: no final result after %0d cycles", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // ********************
    // Helpers
    // ********************
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};  // One step per bit
        end
        return value;
    endfunction

    function automatic logic [31:0] make_addr(input logic [2:0] tg, input logic [3:0] idx);
        return (32'(tg) << (index_bits + 2)) | (32'(idx) << 2);
    endfunction

    task automatic compare_value(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s %s: expected %0h, actual %0h", test, what, expected, actual);
        end
    endtask

    task automatic begin_test();
        checks_at_start = check_count;
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        int errs;
        int checks;
        errs   = error_count - errors_at_start;
        checks = check_count - checks_at_start;
        test_count++;
        if (errs == 0) begin
            $display("test %s: ok, %0d checks", name, checks);
        end else begin
            $display("test %s: failed, %0d of %0d checks wrong", name, errs, checks);
        end
    endtask

    // One request, then wait for done; optional second req while busy
    task automatic run_access(
        input  logic        is_write,
        input  logic [31:0] a,
        input  logic [31:0] d,
        input  logic        poke,
        output logic        got_miss,
        output logic [31:0] got_rdata,
        output int          cycles,
        output logic        busy_seen
    );
        logic finished;
        finished  = 1'b0;
        cycles    = 0;
        busy_seen = 1'b0;
        @(posedge clk);
        req   <= 1'b1;
        we    <= is_write;
        addr  <= a;
        wdata <= d;
        @(posedge clk);  // Request sampled here
        req <= 1'b0;
        while (!finished) begin
            @(posedge clk);
            cycles++;
            if (poke && cycles == 1) begin
                req  <= 1'b1;
                we   <= 1'b0;
                addr <= a ^ (32'd1 << (index_bits + 2));
            end else begin
                req <= 1'b0;
            end
            @(negedge clk);
            if (poke && cycles == 1) begin
                busy_seen = busy;
            end
            finished = done;
        end
        got_miss  = miss;
        got_rdata = rdata;
    endtask

    task automatic check_access(
        input  string       test,
        input  logic        is_write,
        input  logic [2:0]  tg,
        input  logic [3:0]  idx,
        input  logic [31:0] d,
        input  logic        poke,
        output int          cycles
    );
        logic        exp_miss;
        logic [31:0] exp_data;
        logic        got_miss;
        logic [31:0] got_rdata;
        logic        busy_seen;

        // Direct mapped, allocate on every access
        exp_miss = !(model_valid[idx] && model_tag[idx] == tg);
        model_valid[idx] = 1'b1;
        model_tag[idx]   = tg;
        if (is_write) begin
            model_mem[{tg, idx}] = d;
        end
        exp_data = model_mem[{tg, idx}];

        run_access(is_write, make_addr(tg, idx), d, poke, got_miss, got_rdata, cycles,
                   busy_seen);
        compare_value(test, "miss", 32'(exp_miss), 32'(got_miss));
        if (!is_write) begin
            compare_value(test, "rdata", exp_data, got_rdata);
        end
        if (poke) begin
            compare_value(test, "busy at second req", 32'd1, 32'(busy_seen));
        end
    endtask

    task automatic count_done(input int n, output int pulses);
        pulses = 0;
        repeat (n) begin
            @(negedge clk);
            if (done) begin
                pulses++;
            end
        end
    endtask

    // ********************
    // Tests
    // ********************
    task automatic test_reset_reads();
        int cycles;
        begin_test();
        for (int i = 0; i < 16; i++) begin
            check_access("reset_reads", 1'b0, 3'(random_bits(3)), 4'(i), 32'd0, 1'b0, cycles);
        end
        end_test("reset_reads");
    endtask

    task automatic test_write_read();
        logic [2:0] tg;
        logic [3:0] idx;
        int         cycles;
        begin_test();
        repeat (8) begin
            tg  = 3'(random_bits(3));
            idx = 4'(random_bits(4));
            check_access("write_read", 1'b1, tg, idx, random_bits(32), 1'b0, cycles);
            check_access("write_read", 1'b0, tg, idx, 32'd0, 1'b0, cycles);
        end
        end_test("write_read");
    endtask

    task automatic test_conflict();
        logic [2:0] tg_a;
        logic [2:0] tg_b;
        logic [3:0] idx;
        int         cycles;
        begin_test();
        repeat (4) begin
            idx  = 4'(random_bits(4));
            tg_a = 3'(random_bits(3));
            tg_b = tg_a ^ 3'(random_bits(2) + 1);  // Never equal to tg_a
            check_access("conflict_evict", 1'b1, tg_a, idx, random_bits(32), 1'b0, cycles);
            check_access("conflict_evict", 1'(random_bits(1)), tg_b, idx, random_bits(32),
                         1'b0, cycles);
            check_access("conflict_evict", 1'b0, tg_a, idx, 32'd0, 1'b0, cycles);
        end
        end_test("conflict_evict");
    endtask

    task automatic test_random_mix();
        logic        is_write;
        logic [2:0]  tg;
        logic [3:0]  idx;
        logic [31:0] d;
        int          cycles;
        begin_test();
        repeat (n_random) begin
            is_write = 1'(random_bits(1));
            tg       = 3'(random_bits(3));
            idx      = 4'(random_bits(4));
            d        = random_bits(32);
            check_access("random_mix", is_write, tg, idx, d, 1'b0, cycles);
        end
        end_test("random_mix");
    endtask

    task automatic test_hit_timing();
        logic [2:0] tg;
        logic [3:0] idx;
        int         cycles;
        int         pulses;
        begin_test();
        repeat (4) begin
            tg  = 3'(random_bits(3));
            idx = 4'(random_bits(4));
            check_access("hit_timing", 1'b1, tg, idx, random_bits(32), 1'b0, cycles);
            check_access("hit_timing", 1'b0, tg, idx, 32'd0, 1'b1, cycles);
            compare_value("hit_timing", "cycles to done", 32'd2, 32'(cycles));
            count_done(6, pulses);
            compare_value("hit_timing", "extra done", 32'd0, 32'(pulses));
        end
        end_test("hit_timing");
    endtask

    initial begin
        for (int i = 0; i < 128; i++) begin
            model_mem[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            model_tag[i] = '0;
        end
        model_valid = '0;
        rst_b <= 1'b0;
        req   <= 1'b0;
        we    <= 1'b0;
        addr  <= '0;
        wdata <= '0;
        repeat (5) @(posedge clk);
        rst_b <= 1'b1;

        test_reset_reads();
        test_write_read();
        test_conflict();
        test_random_mix();
        test_hit_timing();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/cache_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_checker
    import cache_pkg::*;
(
    input logic         clk,
    input logic         rst_b,
    input logic         busy,
    input logic         done,
    input logic         victim_dirty,
    input mem_cmd_t     mem_cmd,
    input cache_state_t state_q
);

    // ********************
    // Processor handshake
    // ********************
    done_ends_busy: assert property (
        @(posedge clk) disable iff (!rst_b)
        done |-> ($past(busy) && !busy)
    ) else $error("done seen without busy falling on the same edge");

    busy_ends_with_done: assert property (
        @(posedge clk) disable iff (!rst_b)
        ($past(busy) && !busy) |-> done
    ) else $error("busy fell without a done pulse");

    // ********************
    // Memory side
    // ********************
    cmd_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_b)
        (mem_cmd != mem_none) |=> (mem_cmd == mem_none)
    ) else $error("memory command held for more than one cycle");

    // Entry into write-back only from a dirty lookup
    writeback_entry: assert property (
        @(posedge clk) disable iff (!rst_b)
        (state_q == st_writeback && $past(state_q) != st_writeback) |-> $past(victim_dirty)
    ) else $error("write-back state entered without a dirty victim");

endmodule

bind cache_controller cache_checker u_checker (
    .clk          (clk),
    .rst_b        (rst_b),
    .busy         (busy),
    .done         (done),
    .victim_dirty (victim_dirty),
    .mem_cmd      (mem_cmd),
    .state_q      (state_q)
);

`default_nettype wire

/* sim/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int period_ns = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Free running, half period per toggle
    always #(period_ns / 2) clk = ~clk;

endmodule

`default_nettype wire

/* logic/cache_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem
    import cache_pkg::*;
#(
    parameter int index_bits     = 6,   // 64 lines
    parameter int mem_words_bits = 10,  // 1024 words
    parameter int mem_latency    = 3
) (
    input  logic                 clk,
    input  logic                 rst_b,
    input  logic                 req,
    input  logic                 we,
    input  logic [word_bits-1:0] addr,
    input  logic [word_bits-1:0] wdata,
    output logic                 busy,
    output logic                 done,
    output logic                 miss,
    output logic [word_bits-1:0] rdata
);

    localparam int tag_bits = word_bits - index_bits - 2;

    // Controller to array
    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   tag;
    logic                  hit;
    logic                  victim_dirty;
    logic [word_bits-1:0]  victim_addr;
    logic [word_bits-1:0]  line_data;
    logic                  line_we;
    logic [word_bits-1:0]  line_wdata;
    logic                  line_dirty;

    // Controller to memory
    mem_cmd_t              mem_cmd;
    logic [word_bits-1:0]  mem_addr;
    logic [word_bits-1:0]  mem_wdata;
    logic                  mem_ack;
    logic [word_bits-1:0]  mem_rdata;

    cache_controller #(
        .index_bits   (index_bits)
    ) u_controller (
        .clk          (clk),
        .rst_b        (rst_b),
        .req          (req),
        .we           (we),
        .addr         (addr),
        .wdata        (wdata),
        .busy         (busy),
        .done         (done),
        .miss         (miss),
        .rdata        (rdata),
        .index        (index),
        .tag          (tag),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .line_data    (line_data),
        .line_we      (line_we),
        .line_wdata   (line_wdata),
        .line_dirty   (line_dirty),
        .mem_cmd      (mem_cmd),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ack      (mem_ack),
        .mem_rdata    (mem_rdata)
    );

    cache_array #(
        .index_bits   (index_bits)
    ) u_array (
        .clk          (clk),
        .rst_b        (rst_b),
        .index        (index),
        .tag          (tag),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .line_data    (line_data),
        .line_we      (line_we),
        .line_wdata   (line_wdata),
        .line_dirty   (line_dirty)
    );

    backing_memory #(
        .mem_words_bits (mem_words_bits),
        .mem_latency    (mem_latency)
    ) u_memory (
        .clk            (clk),
        .rst_b          (rst_b),
        .mem_cmd        (mem_cmd),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_ack        (mem_ack),
        .mem_rdata      (mem_rdata)
    );

endmodule

`default_nettype wire

/* logic/backing_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module backing_memory
    import cache_pkg::*;
#(
    parameter int mem_words_bits = 10,
    parameter int mem_latency    = 3
) (
    input  logic                 clk,
    input  logic                 rst_b,
    input  mem_cmd_t             mem_cmd,
    input  logic [word_bits-1:0] mem_addr,
    input  logic [word_bits-1:0] mem_wdata,
    output logic                 mem_ack,
    output logic [word_bits-1:0] mem_rdata
);

    localparam int mem_words = 1 << mem_words_bits;

    logic [word_bits-1:0]      storage [mem_words];

    logic [mem_latency-1:0]    delay_q;
    logic [mem_latency-1:0]    delay_d;
    logic                      issue;
    logic                      fire;    // Ack starts next cycle

    // Command held while it ages
    mem_cmd_t                  cmd_q;
    logic [mem_words_bits-1:0] word_q;
    logic [word_bits-1:0]      wdata_q;

    mem_cmd_t                  cmd_sel;
    logic [mem_words_bits-1:0] word_sel;
    logic [word_bits-1:0]      wdata_sel;

    assign issue   = (mem_cmd != mem_none);
    assign delay_d = (delay_q << 1) | mem_latency'(issue);
    assign fire    = delay_d[mem_latency-1];
    assign mem_ack = delay_q[mem_latency-1];

    // A one-cycle latency sees the command still on the inputs
    assign cmd_sel   = issue ? mem_cmd : cmd_q;
    assign word_sel  = issue ? mem_addr[mem_words_bits+1:2] : word_q;
    assign wdata_sel = issue ? mem_wdata : wdata_q;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            delay_q <= '0;
        end else begin
            delay_q <= delay_d;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            cmd_q   <= mem_cmd;
            word_q  <= mem_addr[mem_words_bits+1:2];  // Wraps at memory size
            wdata_q <= mem_wdata;
        end
        if (fire && cmd_sel == mem_read) begin
            mem_rdata <= storage[word_sel];
        end
    end

    // ********************
    // Word storage
    // ********************
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < mem_words; i++) begin
                storage[i] <= '0;
            end
        end else if (fire && cmd_sel == mem_write) begin
            storage[word_sel] <= wdata_sel;
        end
    end

endmodule

`default_nettype wire

/* logic/cache_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_controller
    import cache_pkg::*;
#(
    parameter int index_bits = 6
) (
    input  logic                                  clk,
    input  logic                                  rst_b,

    // Processor side
    input  logic                                  req,
    input  logic                                  we,
    input  logic [word_bits-1:0]                  addr,
    input  logic [word_bits-1:0]                  wdata,
    output logic                                  busy,
    output logic                                  done,
    output logic                                  miss,
    output logic [word_bits-1:0]                  rdata,

    // Array
    output logic [index_bits-1:0]                 index,
    output logic [word_bits-index_bits-3:0]       tag,
    input  logic                                  hit,
    input  logic                                  victim_dirty,
    input  logic [word_bits-1:0]                  victim_addr,
    input  logic [word_bits-1:0]                  line_data,
    output logic                                  line_we,
    output logic [word_bits-1:0]                  line_wdata,
    output logic                                  line_dirty,

    // Main memory
    output mem_cmd_t                              mem_cmd,
    output logic [word_bits-1:0]                  mem_addr,
    output logic [word_bits-1:0]                  mem_wdata,
    input  logic                                  mem_ack,
    input  logic [word_bits-1:0]                  mem_rdata
);

    cache_state_t state_q;
    cache_state_t state_d;

    logic [word_bits-1:0] req_addr;
    logic [word_bits-1:0] req_wdata;
    logic                 req_we;
    logic [word_bits-1:0] data_q;   // Word for the response
    logic                 miss_q;
    logic                 accept;

    assign accept = (state_q == st_idle) && req;

    assign index = req_addr[index_bits+1:2];
    assign tag   = req_addr[word_bits-1:index_bits+2];

    // ********************
    // Next state and array/memory strobes
    // ********************
    always_comb begin
        state_d    = state_q;
        line_we    = 1'b0;
        line_wdata = req_wdata;
        line_dirty = 1'b1;
        mem_cmd    = mem_none;
        mem_addr   = {req_addr[word_bits-1:2], 2'b00};
        mem_wdata  = line_data;

        case (state_q)
            st_idle: begin
                if (req) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                if (hit) begin
                    line_we = req_we;  // Write hit just marks the line dirty
                    state_d = st_respond;
                end else if (victim_dirty) begin
                    mem_cmd  = mem_write;
                    mem_addr = victim_addr;
                    state_d  = st_writeback;
                end else if (req_we) begin
                    line_we = 1'b1;    // Allocate without refill
                    state_d = st_respond;
                end else begin
                    mem_cmd = mem_read;
                    state_d = st_refill;
                end
            end
            st_writeback: begin
                if (mem_ack) begin
                    if (req_we) begin
                        line_we = 1'b1;
                        state_d = st_respond;
                    end else begin
                        mem_cmd = mem_read;
                        state_d = st_refill;
                    end
                end
            end
            st_refill: begin
                if (mem_ack) begin
                    line_we    = 1'b1;
                    line_wdata = mem_rdata;
                    line_dirty = 1'b0;
                    state_d    = st_respond;
                end
            end
            st_respond: state_d = st_idle;
            default:    state_d = st_idle;
        endcase
    end

    // ********************
    // Control registers
    // ********************
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state_q <= st_idle;
            busy    <= 1'b0;
            done    <= 1'b0;
            miss    <= 1'b0;
            miss_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done    <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
            end
            if (state_q == st_lookup) begin
                miss_q <= !hit;
            end
            // Done and busy release on the same edge
            if (state_q == st_respond) begin
                done <= 1'b1;
                busy <= 1'b0;
                miss <= miss_q;
            end
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= addr;
            req_we    <= we;
            req_wdata <= wdata;
        end
        if (state_q == st_lookup && hit) begin
            data_q <= line_data;
        end
        if (state_q == st_refill && mem_ack) begin
            data_q <= mem_rdata;  // Fresh word from memory
        end
        if (state_q == st_respond) begin
            rdata <= data_q;
        end
    end

endmodule

`default_nettype wire

/* logic/cache_array.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_array
    import cache_pkg::*;
#(
    parameter int index_bits = 6
) (
    input  logic                                  clk,
    input  logic                                  rst_b,

    // Lookup
    input  logic [index_bits-1:0]                 index,
    input  logic [word_bits-index_bits-3:0]       tag,
    output logic                                  hit,
    output logic                                  victim_dirty,
    output logic [word_bits-1:0]                  victim_addr,
    output logic [word_bits-1:0]                  line_data,

    // Line write
    input  logic                                  line_we,
    input  logic [word_bits-1:0]                  line_wdata,
    input  logic                                  line_dirty
);

    localparam int tag_bits = word_bits - index_bits - 2;
    localparam int lines    = 1 << index_bits;

    // ********************
    // Storage
    // ********************
    logic [tag_bits-1:0]  tags_q [lines];
    logic [word_bits-1:0] data_q [lines];
    logic [lines-1:0]     valid_q;
    logic [lines-1:0]     dirty_q;

    logic [tag_bits-1:0]  stored_tag;

    assign stored_tag = tags_q[index];

    // ********************
    // Lookup
    // ********************
    assign hit          = valid_q[index] && (stored_tag == tag);
    assign victim_dirty = valid_q[index] && dirty_q[index];
    assign victim_addr  = {stored_tag, index, 2'b00};  // Where the old line lives
    assign line_data    = data_q[index];

    // Status bits, cleared at reset
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (line_we) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= line_dirty;  // Refill writes clean
        end
    end

    // Tag and word follow the status bits on every line write
    always_ff @(posedge clk) begin
        if (line_we) begin
            tags_q[index] <= tag;
            data_q[index] <= line_wdata;
        end
    end

endmodule

`default_nettype wire

/* logic/cache_pkg.sv */
`default_nettype none

package cache_pkg;

    // ********************
    // Widths
    // ********************
    localparam int word_bits = 32;  // Data word and byte address

    // ********************
    // Encodings
    // ********************

    // Command from the miss controller to main memory
    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_read  = 2'd1,
        mem_write = 2'd2
    } mem_cmd_t;

    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_lookup    = 3'd1,
        st_writeback = 3'd2,  // Dirty victim on its way out
        st_refill    = 3'd3,
        st_respond   = 3'd4
    } cache_state_t;

endpackage

`default_nettype wire
